// File: cacheTagSubsystem.f
common/cacheLinePkg.sv
common/cacheReqPkg.sv
tagMemory/lineTagUnit.sv
tagMemory/setAssocTagMemory.sv
verilog/replacementCounter.sv
verilog/cacheTagController.sv
verilog/cacheTagSubsystem.sv
tb/cacheTagSubsystemTb.sv

// File: common/cacheLinePkg.sv
package cacheLinePkg;

	// tag and set index geometry
	localparam int TAG_WIDTH = 8;
	localparam int INDEX_WIDTH = 4;
	localparam int NUM_SETS = 1 << INDEX_WIDTH;

	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;

	// MESI-style line states, INVALID must stay the all-zero encoding
	typedef enum logic [1:0] {
		INVALID = 2'd0,
		SHARED = 2'd1,
		EXCLUSIVE = 2'd2,
		MODIFIED = 2'd3
	} lineState_t;

endpackage : cacheLinePkg

// File: common/cacheReqPkg.sv
package cacheReqPkg;

	import cacheLinePkg::*;

	// request opcodes
	typedef enum logic [1:0] {
		OP_LOOKUP = 2'd0,
		OP_FILL = 2'd1,
		OP_SET_STATE = 2'd2,
		OP_INVALIDATE = 2'd3
	} cacheOp_t;

	// one client request, 16 bits
	typedef struct packed {
		cacheOp_t op;
		index_t index;
		tag_t tag;
		// new state for fill and set-state
		lineState_t state;
	} cacheReq_t;

	// response, 12 bits
	typedef struct packed {
		logic hit;
		lineState_t oldState;
		logic evictValid;
		tag_t evictTag;
	} cacheResp_t;

endpackage : cacheReqPkg

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert --top-module cacheTagSubsystemTb \
	-f cacheTagSubsystem.f -o cacheTagSim || exit 1
output=$(./obj_dir/cacheTagSim)
echo "$output"
echo "$output" | grep -q "Simulation finished: PASS" && exit 0 || exit 1

// File: tagMemory/lineTagUnit.sv
`timescale 1ns/100ps

module lineTagUnit import cacheLinePkg::*; (
	input logic clock,
	input logic rstN,
	input index_t index,
	input tag_t tagIn,
	input lineState_t stateIn,
	input logic writeTag,
	input logic writeState,
	output tag_t tagOut,
	output lineState_t stateOut,
	output logic hit
);

	// one entry per set for this way
	tag_t tags [NUM_SETS];
	lineState_t states [NUM_SETS];

	// tags carry no valid meaning on their own
	always_ff @(posedge clock) begin
		if (writeTag) begin
			tags[index] <= tagIn;
		end
	end

	// every line starts out invalid
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				states[i] <= INVALID;
			end
		end else if (writeState) begin
			states[index] <= stateIn;
		end
	end

	// combinational read of the indexed entry
	assign tagOut = tags[index];
	assign stateOut = states[index];

	// only a valid line can match
	assign hit = (states[index] != INVALID) && (tags[index] == tagIn);

endmodule : lineTagUnit

// File: tagMemory/setAssocTagMemory.sv
`timescale 1ns/100ps

module setAssocTagMemory import cacheLinePkg::*; #(
	parameter int WAY_BITS = 2
) (
	input logic clock,
	input logic rstN,
	input index_t index,
	input tag_t tagIn,
	input lineState_t stateIn,
	// way that receives the write strobes and drives selTag / selState
	input logic [WAY_BITS-1:0] wayIn,
	input logic writeTag,
	input logic writeState,
	output logic hit,
	output logic [WAY_BITS-1:0] hitWay,
	output lineState_t hitState,
	output tag_t selTag,
	output lineState_t selState
);

	localparam int NUM_WAYS = 1 << WAY_BITS;

	logic [NUM_WAYS-1:0] wayWriteTag;
	logic [NUM_WAYS-1:0] wayWriteState;
	logic [NUM_WAYS-1:0] wayHit;
	tag_t wayTag [NUM_WAYS];
	lineState_t wayState [NUM_WAYS];

	// index, tag and state go to every way unchanged
	for (genvar w = 0; w < NUM_WAYS; w++) begin : gWay
		lineTagUnit way (
			.clock(clock),
			.rstN(rstN),
			.index(index),
			.tagIn(tagIn),
			.stateIn(stateIn),
			.writeTag(wayWriteTag[w]),
			.writeState(wayWriteState[w]),
			.tagOut(wayTag[w]),
			.stateOut(wayState[w]),
			.hit(wayHit[w])
		);
	end

	// write strobe demultiplexers
	always_comb begin
		wayWriteTag = '0;
		wayWriteState = '0;
		wayWriteTag[wayIn] = writeTag;
		wayWriteState[wayIn] = writeState;
	end

	assign hit = |wayHit;

	// at most one way hits, so a plain scan is enough
	always_comb begin
		hitWay = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (wayHit[i]) begin
				hitWay = WAY_BITS'(i);
			end
		end
	end

	assign hitState = hit ? wayState[hitWay] : INVALID;

	// read multiplexers for the selected way
	assign selTag = wayTag[wayIn];
	assign selState = wayState[wayIn];

endmodule : setAssocTagMemory

// File: tb/cacheTagSubsystemTb.sv
`timescale 1ns/100ps

module cacheTagSubsystemTb import cacheLinePkg::*; import cacheReqPkg::*; ();

	localparam int WAY_BITS = 2;
	localparam int NUM_WAYS = 1 << WAY_BITS;
	// about 430 requests of 3 cycles each plus reset and the busy-test gaps
	localparam int MAX_CYCLES = 3000;

	logic clock;
	logic rstN;
	logic reqValid;
	cacheReq_t req;
	logic busy;
	logic respValid;
	cacheResp_t resp;
	logic [WAY_BITS-1:0] respWay;

	// reference model of every set and its round-robin pointer
	tag_t modelTag [NUM_SETS][NUM_WAYS];
	lineState_t modelState [NUM_SETS][NUM_WAYS];
	logic [WAY_BITS-1:0] modelPtr [NUM_SETS];

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int cycleCount = 0;
	cacheResp_t lastResp;
	logic [WAY_BITS-1:0] lastWay;

	cacheTagSubsystem #(.WAY_BITS(WAY_BITS)) dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		while (cycleCount < MAX_CYCLES) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	task automatic checkValue(input string testName, input string what,
		input logic [15:0] expected, input logic [15:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			$display("ERR %s %s expected %0h actual %0h", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string testName, input int startErrors);
		testCount++;
		$display("test %s finished with %0d errors", testName, errorCount - startErrors);
	endtask

	// sends one request and checks it against the model before updating the model
	task automatic sendRequest(input string testName, input cacheOp_t reqOp,
		input index_t reqIndex, input tag_t reqTag, input lineState_t reqState);
		logic expHit = 1'b0;
		logic expEvict;
		logic [WAY_BITS-1:0] expWay;
		int edges = 0;
		expWay = modelPtr[reqIndex];
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (modelState[reqIndex][w] != INVALID && modelTag[reqIndex][w] == reqTag) begin
				expHit = 1'b1;
				expWay = WAY_BITS'(w);
			end
		end
		expEvict = (reqOp == OP_FILL) && !expHit && (modelState[reqIndex][expWay] != INVALID);
		req = '{reqOp, reqIndex, reqTag, reqState};
		reqValid = 1'b1;
		@(posedge clock);
		#1;
		reqValid = 1'b0;
		while (!respValid && edges < 4) begin
			@(posedge clock);
			#1;
			edges++;
		end
		assert (respValid) else begin
			$display("%s: no response came for an accepted request", testName);
			errorCount++;
		end
		lastResp = resp;
		lastWay = respWay;
		// respValid follows the accepting edge by one edge
		checkValue(testName, "response edge", 16'(1), 16'(edges));
		checkValue(testName, "hit", 16'(expHit), 16'(resp.hit));
		checkValue(testName, "oldState", 16'(expHit ? modelState[reqIndex][expWay] : INVALID),
			16'(resp.oldState));
		checkValue(testName, "evictValid", 16'(expEvict), 16'(resp.evictValid));
		if (expEvict) begin
			checkValue(testName, "evictTag", 16'(modelTag[reqIndex][expWay]), 16'(resp.evictTag));
		end
		if (expHit || reqOp == OP_FILL) begin
			checkValue(testName, "respWay", 16'(expWay), 16'(respWay));
		end
		if (reqOp == OP_FILL) begin
			modelTag[reqIndex][expWay] = reqTag;
			modelState[reqIndex][expWay] = reqState;
			modelPtr[reqIndex] = modelPtr[reqIndex] + WAY_BITS'(!expHit);
		end else if (reqOp != OP_LOOKUP && expHit) begin
			modelState[reqIndex][expWay] = (reqOp == OP_INVALIDATE) ? INVALID : reqState;
		end
		@(posedge clock);
		#1;
		checkValue(testName, "respValid after pulse", 16'(0), 16'(respValid));
		checkValue(testName, "busy after response", 16'(0), 16'(busy));
	endtask

	task automatic resetTest();
		int startErrors = errorCount;
		checkValue("reset", "busy", 16'(0), 16'(busy));
		checkValue("reset", "respValid", 16'(0), 16'(respValid));
		for (int i = 0; i < NUM_SETS; i += 5) begin
			sendRequest("reset", OP_LOOKUP, index_t'(i), 8'h3c, INVALID);
		end
		finishTest("reset", startErrors);
	endtask

	task automatic fillOrderTest();
		int startErrors = errorCount;
		for (int i = 0; i < NUM_WAYS; i++) begin
			sendRequest("fillOrder", OP_FILL, 4'd3, tag_t'(8'ha0 + i), lineState_t'(2'(i % 3 + 1)));
			checkValue("fillOrder", "fill way", 16'(i), 16'(lastWay));
		end
		for (int i = 0; i < NUM_WAYS; i++) begin
			sendRequest("fillOrder", OP_LOOKUP, 4'd3, tag_t'(8'ha0 + i), INVALID);
			checkValue("fillOrder", "lookup hit", 16'(1), 16'(lastResp.hit));
		end
		finishTest("fillOrder", startErrors);
	endtask

	task automatic evictTest();
		int startErrors = errorCount;
		sendRequest("evict", OP_FILL, 4'd3, 8'ha4, SHARED);
		checkValue("evict", "evictValid", 16'(1), 16'(lastResp.evictValid));
		checkValue("evict", "evictTag", 16'(8'ha0), 16'(lastResp.evictTag));
		checkValue("evict", "victim way", 16'(0), 16'(lastWay));
		sendRequest("evict", OP_LOOKUP, 4'd3, 8'ha0, INVALID);
		checkValue("evict", "evicted tag hit", 16'(0), 16'(lastResp.hit));
		// a fill hit keeps its way and leaves the pointer alone
		sendRequest("evict", OP_FILL, 4'd3, 8'ha2, EXCLUSIVE);
		checkValue("evict", "refill way", 16'(2), 16'(lastWay));
		sendRequest("evict", OP_LOOKUP, 4'd3, 8'ha2, INVALID);
		checkValue("evict", "refill state", 16'(EXCLUSIVE), 16'(lastResp.oldState));
		sendRequest("evict", OP_FILL, 4'd3, 8'ha5, SHARED);
		checkValue("evict", "next victim way", 16'(1), 16'(lastWay));
		finishTest("evict", startErrors);
	endtask

	task automatic stateTest();
		int startErrors = errorCount;
		sendRequest("state", OP_SET_STATE, 4'd3, 8'ha3, MODIFIED);
		sendRequest("state", OP_LOOKUP, 4'd3, 8'ha3, INVALID);
		checkValue("state", "new state", 16'(MODIFIED), 16'(lastResp.oldState));
		sendRequest("state", OP_INVALIDATE, 4'd3, 8'ha3, MODIFIED);
		sendRequest("state", OP_LOOKUP, 4'd3, 8'ha3, INVALID);
		checkValue("state", "hit after invalidate", 16'(0), 16'(lastResp.hit));
		// misses must leave every line as it was
		sendRequest("state", OP_SET_STATE, 4'd3, 8'hee, MODIFIED);
		sendRequest("state", OP_INVALIDATE, 4'd3, 8'hee, INVALID);
		for (int i = 0; i < 6; i++) begin
			sendRequest("state", OP_LOOKUP, 4'd3, tag_t'(8'ha0 + i), INVALID);
		end
		finishTest("state", startErrors);
	endtask

	task automatic randomTest();
		int startErrors = errorCount;
		tag_t tagPool [6] = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66};
		for (int i = 0; i < 400; i++) begin
			sendRequest("random", cacheOp_t'(2'($urandom % 4)), index_t'(8 + $urandom % 4),
				tagPool[$urandom % 6], lineState_t'(2'($urandom % 4)));
		end
		sendRequest("random", OP_LOOKUP, 4'd3, 8'ha2, INVALID);
		checkValue("random", "other set hit", 16'(1), 16'(lastResp.hit));
		finishTest("random", startErrors);
	endtask

	task automatic busyTest();
		int startErrors = errorCount;
		int extraResponses = 0;
		req = '{OP_LOOKUP, 4'd3, 8'ha2, INVALID};
		reqValid = 1'b1;
		@(posedge clock);
		#1;
		// this fill stays on reqValid through both busy cycles and must be dropped
		req = '{OP_FILL, 4'd13, 8'h77, MODIFIED};
		checkValue("busy", "busy after accept", 16'(1), 16'(busy));
		@(posedge clock);
		#1;
		checkValue("busy", "first respValid", 16'(1), 16'(respValid));
		checkValue("busy", "hit", 16'(1), 16'(resp.hit));
		@(posedge clock);
		#1;
		reqValid = 1'b0;
		repeat (6) begin
			if (respValid) extraResponses++;
			@(posedge clock);
			#1;
		end
		checkValue("busy", "extra responses", 16'(0), 16'(extraResponses));
		sendRequest("busy", OP_LOOKUP, 4'd13, 8'h77, INVALID);
		finishTest("busy", startErrors);
	endtask

	initial begin
		int seed;
		seed = $urandom(79);
		rstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		for (int s = 0; s < NUM_SETS; s++) begin
			modelPtr[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				modelTag[s][w] = '0;
				modelState[s][w] = INVALID;
			end
		end
		repeat (3) @(posedge clock);
		#1;
		rstN = 1'b1;
		resetTest();
		fillOrderTest();
		evictTest();
		stateTest();
		randomTest();
		busyTest();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule : cacheTagSubsystemTb

// File: verilog/cacheTagController.sv
`timescale 1ns/100ps

module cacheTagController import cacheLinePkg::*; import cacheReqPkg::*; #(
	parameter int WAY_BITS = 2
) (
	input logic clock,
	input logic rstN,
	input logic reqValid,
	input cacheReq_t req,
	output logic busy,
	output logic respValid,
	output cacheResp_t resp,
	output logic [WAY_BITS-1:0] respWay,
	output index_t memIndex,
	output tag_t memTag,
	output lineState_t memState,
	output logic [WAY_BITS-1:0] memWay,
	output logic writeTag,
	output logic writeState,
	input logic hit,
	input logic [WAY_BITS-1:0] hitWay,
	input lineState_t hitState,
	input lineState_t selState,
	input tag_t selTag,
	input logic [WAY_BITS-1:0] victimWay,
	output logic advance
);

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		UPDATE
	} ctrlState_t;

	ctrlState_t ctrlState;
	ctrlState_t nextState;
	cacheReq_t reqReg;

	// lookup results, captured at the end of LOOKUP
	logic hitReg;
	logic [WAY_BITS-1:0] hitWayReg;
	lineState_t hitStateReg;
	logic [WAY_BITS-1:0] victimWayReg;
	tag_t victimTagReg;
	lineState_t victimStateReg;

	logic isFill;
	logic fillMiss;

	always_comb begin
		nextState = ctrlState;
		case (ctrlState)
			IDLE: if (reqValid) nextState = LOOKUP;
			LOOKUP: nextState = UPDATE;
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			ctrlState <= IDLE;
		end else begin
			ctrlState <= nextState;
		end
	end

	always_ff @(posedge clock) begin
		if (ctrlState == IDLE && reqValid) begin
			reqReg <= req;
		end
		if (ctrlState == LOOKUP) begin
			hitReg <= hit;
			hitWayReg <= hitWay;
			hitStateReg <= hitState;
			victimWayReg <= victimWay;
			victimTagReg <= selTag;
			victimStateReg <= selState;
		end
	end

	assign isFill = (reqReg.op == OP_FILL);
	assign fillMiss = isFill && !hitReg;

	// memory side, way follows the counter during lookup
	assign memIndex = reqReg.index;
	assign memTag = reqReg.tag;
	assign memState = (reqReg.op == OP_INVALIDATE) ? INVALID : reqReg.state;
	assign memWay = (ctrlState == UPDATE) ?
		(hitReg ? hitWayReg : victimWayReg) : victimWay;

	// strobes only in UPDATE
	assign writeTag = (ctrlState == UPDATE) && isFill;
	assign writeState = (ctrlState == UPDATE) && (isFill ||
		(hitReg && (reqReg.op == OP_SET_STATE || reqReg.op == OP_INVALIDATE)));
	assign advance = (ctrlState == UPDATE) && fillMiss;

	assign busy = (ctrlState != IDLE);
	assign respValid = (ctrlState == UPDATE);

	assign resp.hit = hitReg;
	assign resp.oldState = hitReg ? hitStateReg : INVALID;
	// a writeback would start from here
	assign resp.evictValid = fillMiss && (victimStateReg != INVALID);
	assign resp.evictTag = victimTagReg;
	assign respWay = hitReg ? hitWayReg : victimWayReg;

endmodule : cacheTagController

// File: verilog/cacheTagSubsystem.sv
`timescale 1ns/100ps

module cacheTagSubsystem import cacheLinePkg::*; import cacheReqPkg::*; #(
	parameter int WAY_BITS = 2
) (
	input logic clock,
	input logic rstN,
	input logic reqValid,
	input cacheReq_t req,
	output logic busy,
	output logic respValid,
	output cacheResp_t resp,
	output logic [WAY_BITS-1:0] respWay
);

	index_t memIndex;
	tag_t memTag;
	lineState_t memState;
	logic [WAY_BITS-1:0] memWay;
	logic writeTag;
	logic writeState;
	logic hit;
	logic [WAY_BITS-1:0] hitWay;
	lineState_t hitState;
	tag_t selTag;
	lineState_t selState;
	logic [WAY_BITS-1:0] victimWay;
	logic advance;

	cacheTagController #(
		.WAY_BITS(WAY_BITS)
	) controller0 (
		.clock(clock),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.busy(busy),
		.respValid(respValid),
		.resp(resp),
		.respWay(respWay),
		.memIndex(memIndex),
		.memTag(memTag),
		.memState(memState),
		.memWay(memWay),
		.writeTag(writeTag),
		.writeState(writeState),
		.hit(hit),
		.hitWay(hitWay),
		.hitState(hitState),
		.selState(selState),
		.selTag(selTag),
		.victimWay(victimWay),
		.advance(advance)
	);

	// victim pointer shares the controller's index
	replacementCounter #(
		.WAY_BITS(WAY_BITS)
	) counter0 (
		.clock(clock),
		.rstN(rstN),
		.index(memIndex),
		.advance(advance),
		.victimWay(victimWay)
	);

	setAssocTagMemory #(
		.WAY_BITS(WAY_BITS)
	) tagMemory0 (
		.clock(clock),
		.rstN(rstN),
		.index(memIndex),
		.tagIn(memTag),
		.stateIn(memState),
		.wayIn(memWay),
		.writeTag(writeTag),
		.writeState(writeState),
		.hit(hit),
		.hitWay(hitWay),
		.hitState(hitState),
		.selTag(selTag),
		.selState(selState)
	);

endmodule : cacheTagSubsystem

// File: verilog/replacementCounter.sv
`timescale 1ns/100ps

module replacementCounter import cacheLinePkg::*; #(
	parameter int WAY_BITS = 2
) (
	input logic clock,
	input logic rstN,
	input index_t index,
	input logic advance,
	output logic [WAY_BITS-1:0] victimWay
);

	// round-robin pointer per set
	logic [WAY_BITS-1:0] pointers [NUM_SETS];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				pointers[i] <= '0;
			end
		end else if (advance) begin
			// wraps at the number of ways by its width
			pointers[index] <= pointers[index] + 1'b1;
		end
	end

	assign victimWay = pointers[index];

endmodule : replacementCounter
